/* project.f */
+incdir+logic
logic/board_pkg.sv
logic/media_pkg.sv
logic/rom_store.sv
logic/rom_loader.sv
logic/input_mapper.sv
logic/video_blanker.sv
logic/audio_dac.sv
logic/arcade_glue_top.sv
testbench/tb_arcade_glue.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the arcade glue testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f \
	--top-module tb_arcade_glue -Mdir obj_dir

./obj_dir/Vtb_arcade_glue > sim.log || { cat sim.log; exit 1; }
cat sim.log

if grep -q "Errors found" sim.log; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation passed"

/* testbench/tb_arcade_glue.sv */
/*
 * Testbench for the arcade board glue: ROM load, controls, video, audio
 * and core reset requests, checked against reference rules
 */
`default_nettype none
`include "arcade_macros.svh"

module tb_arcade_glue;

	import board_pkg::*;
	import media_pkg::*;

	localparam int CLK_PERIOD = 100;
	localparam int DRIVE_DELAY = 10;
	localparam int ROM_BYTES = 64;
	localparam int JOY_ROUNDS = 16;
	localparam int AUDIO_CYCLES = 4096;
	localparam int WATCHDOG_CYCLES = (8 + 2 * ROM_BYTES + 8) + 62 + JOY_ROUNDS * 4
		+ 4 * 8 * 12 + 4 * AUDIO_CYCLES + 2 * 14 + 1000;
	// Ordered as the bits of {ctrl, cabinet}, MSB first
	localparam logic [7:0] KEY_CODES [14] = '{`KEY_UP, `KEY_DOWN, `KEY_LEFT, `KEY_RIGHT,
		`KEY_FIRE1, `KEY_FIRE2, `KEY_FIRE3, `KEY_FIRE4, `KEY_COIN, `KEY_START1,
		`KEY_START2, `KEY_ADVANCE, `KEY_AUTO_UP, `KEY_SCORE_RESET};

	logic clk_sys = 1'b0;
	logic rst_n;
	logic dl_active;
	logic dl_wr;
	rom_wr_t dl_data;
	logic key_strobe;
	key_event_t key_event;
	joy_t joy0;
	joy_t joy1;
	logic board_reset_btn;
	menu_t menu;
	logic [`ROM_ADDR_W-1:0] rom_addr;
	vid_in_t core_vid;
	logic [7:0] core_audio;
	logic [7:0] rom_data;
	logic core_reset;
	player_ctrl_t ctrl;
	cabinet_t cabinet;
	vid_out_t vid_out;
	logic audio_bit;

	int checks = 0;
	int errors = 0;
	int test_start_errors = 0;
	logic [13:0] kb_state = '0; // Held keys, same order as KEY_CODES
	logic [`ROM_ADDR_W-1:0] rom_addrs [ROM_BYTES];
	logic [7:0] rom_bytes [ROM_BYTES];

	arcade_glue_top u_dut (
		.clk_sys (clk_sys), .rst_n (rst_n), .dl_active (dl_active), .dl_wr (dl_wr),
		.dl_data (dl_data), .key_strobe (key_strobe), .key_event (key_event),
		.joy0 (joy0), .joy1 (joy1), .board_reset_btn (board_reset_btn), .menu (menu),
		.rom_addr (rom_addr), .core_vid (core_vid), .core_audio (core_audio),
		.rom_data (rom_data), .core_reset (core_reset), .ctrl (ctrl), .cabinet (cabinet),
		.vid_out (vid_out), .audio_bit (audio_bit)
	);

	always #(CLK_PERIOD / 2) clk_sys = !clk_sys;

	// Any reset source must hold the core in reset on the next edge
	a_reset_sources: assert property (@(posedge clk_sys)
		(!rst_n || dl_active || menu.reset_req || board_reset_btn) |=> core_reset)
		else begin
			$display("Reset source was active but core_reset was low a cycle later");
			errors++;
		end

	task automatic next_cycle();
		@(posedge clk_sys);
		#DRIVE_DELAY;
	endtask

	task automatic check_val(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		checks++;
		assert (act === exp) else begin
			$display("Fail %s expected %h got %h at %0t", name, exp, act, $time);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		$display("Test %s finished with %0d errors", name, errors - test_start_errors);
		test_start_errors = errors;
	endtask

	function automatic int key_index(input logic [7:0] code);
		for (int i = 0; i < 14; i++) begin
			if (KEY_CODES[i] == code) return i;
		end
		return -1;
	endfunction

	function automatic player_ctrl_t ref_ctrl(input player_ctrl_t kb, input joy_t j0,
		input joy_t j1, input logic rot);
		player_ctrl_t c;
		logic u;
		logic d;
		logic l;
		logic r;
		u = kb.up | j0.up | j1.up;
		d = kb.down | j0.down | j1.down;
		l = kb.left | j0.left | j1.left;
		r = kb.right | j0.right | j1.right;
		c.fire1 = kb.fire1 | j0.fire1 | j1.fire1;
		c.fire2 = kb.fire2 | j0.fire2 | j1.fire2;
		c.fire3 = kb.fire3 | j0.fire3 | j1.fire3;
		c.fire4 = kb.fire4 | j0.fire4 | j1.fire4;
		c.up = rot ? u : r; // Quarter turn when rotate is clear
		c.down = rot ? d : l;
		c.left = rot ? l : u;
		c.right = rot ? r : d;
		return c;
	endfunction

	task automatic check_controls();
		check_val("ctrl", 32'(ref_ctrl(player_ctrl_t'(kb_state[13:6]), joy0, joy1,
			menu.rotate)), 32'(ctrl));
		check_val("cabinet", 32'(kb_state[5:0]), 32'(cabinet));
	endtask

	// Strobe one key event, outputs follow two cycles later
	task automatic send_key(input logic [7:0] code, input logic pressed);
		int idx;
		idx = key_index(code);
		key_event.code = code;
		key_event.pressed = pressed;
		key_strobe = 1'b1;
		next_cycle();
		key_strobe = 1'b0;
		check_controls();
		if (idx >= 0) kb_state[13 - idx] = pressed;
		next_cycle();
		check_controls();
	endtask

	function automatic logic [5:0] scanline_dim(input logic [5:0] c, input logic [1:0] level);
		case (level)
			2'd1: return c - c / 6'd4;
			2'd2: return c / 6'd2;
			2'd3: return c / 6'd4;
			default: return c;
		endcase
	endfunction

	function automatic vid_out_t ref_video(input vid_in_t v, input logic odd,
		input logic [1:0] level);
		vid_out_t o;
		o.r = {v.pix.r, v.pix.r};
		o.g = {v.pix.g, v.pix.g};
		o.b = {v.pix.b, v.pix.b[0], v.pix.b, v.pix.b[0]};
		if (odd) begin
			o.r = scanline_dim(o.r, level);
			o.g = scanline_dim(o.g, level);
			o.b = scanline_dim(o.b, level);
		end
		if (!v.blankn) begin
			o.r = '0;
			o.g = '0;
			o.b = '0;
		end
		o.hs = v.hs;
		o.vs = v.vs;
		return o;
	endfunction

	task automatic readback_rom(input int count);
		for (int i = 0; i < count; i++) begin
			rom_addr = rom_addrs[i];
			next_cycle();
			check_val("rom_data", 32'(rom_bytes[i]), 32'(rom_data));
		end
	endtask

	task automatic reset_request(input logic from_menu);
		check_val("core_reset", 32'(1'b0), 32'(core_reset));
		if (from_menu) menu.reset_req = 1'b1;
		else board_reset_btn = 1'b1;
		for (int i = 0; i < 4; i++) begin
			next_cycle();
			check_val("core_reset", 32'(1'b1), 32'(core_reset));
		end
		menu.reset_req = 1'b0;
		board_reset_btn = 1'b0;
		next_cycle();
		check_val("core_reset", 32'(1'b0), 32'(core_reset));
		readback_rom(8); // ROM must survive the request
	endtask

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired before the tests completed");
		$display("Errors found");
		$finish;
	end

	initial begin
		logic [14:0] base;
		logic [7:0] code;
		logic odd;
		logic hs_prev;
		vid_out_t exp_vid;
		logic [7:0] samples [4];
		logic [15:0] level16;
		int ones;
		longint diff;
		void'($urandom(39));
		rst_n = 1'b0;
		dl_active = 1'b0;
		dl_wr = 1'b0;
		dl_data = '0;
		key_strobe = 1'b0;
		key_event = '0;
		joy0 = '0;
		joy1 = '0;
		board_reset_btn = 1'b0;
		menu = '0;
		rom_addr = '0;
		core_vid = '0;
		core_audio = '0;
		repeat (8) next_cycle();
		rst_n = 1'b1;
		check_val("core_reset", 32'(1'b1), 32'(core_reset));
		check_val("ctrl", 32'(0), 32'(ctrl));
		check_val("cabinet", 32'(0), 32'(cabinet));
		check_val("vid_out", 32'(0), 32'(vid_out));
		check_val("audio_bit", 32'(0), 32'(audio_bit));

		// ROM download of a random 64-byte block
		dl_active = 1'b1;
		next_cycle();
		base = 15'(($urandom % 256) * 64);
		for (int i = 0; i < ROM_BYTES; i++) begin
			rom_addrs[i] = base + 15'(i);
			rom_bytes[i] = 8'($urandom);
			dl_data.addr = rom_addrs[i];
			dl_data.data = rom_bytes[i];
			dl_wr = 1'b1;
			next_cycle();
			check_val("core_reset", 32'(1'b1), 32'(core_reset));
		end
		dl_wr = 1'b0;
		dl_active = 1'b0;
		next_cycle();
		check_val("core_reset", 32'(1'b1), 32'(core_reset)); // Loaded flag not yet seen
		next_cycle();
		check_val("core_reset", 32'(1'b0), 32'(core_reset));
		readback_rom(ROM_BYTES);
		end_test("rom_load");

		menu.rotate = 1'b1;
		for (int i = 0; i < 14; i++) begin
			send_key(KEY_CODES[i], 1'b1);
			send_key(KEY_CODES[i], 1'b0);
		end
		send_key(8'h00, 1'b1);
		send_key(8'hFF, 1'b1);
		do code = 8'($urandom); while (key_index(code) >= 0);
		send_key(code, 1'b1);
		end_test("keyboard");

		for (int i = 0; i < JOY_ROUNDS; i++) begin
			send_key(KEY_CODES[$urandom % 8], 1'($urandom));
			joy0 = joy_t'(8'($urandom));
			joy1 = joy_t'(8'($urandom));
			menu.rotate = 1'b1;
			next_cycle();
			check_controls();
			menu.rotate = 1'b0;
			next_cycle();
			check_controls();
		end
		end_test("joystick");

		odd = 1'b0;
		hs_prev = 1'b0;
		for (int level = 0; level < 4; level++) begin
			menu.scanlines = 2'(level);
			for (int line = 0; line < 8; line++) begin
				for (int px = 0; px < 12; px++) begin
					core_vid.pix = pixel_t'(8'($urandom));
					core_vid.vs = (line == 0);
					core_vid.hs = (px < 2);
					core_vid.blankn = (px >= 3) && ($urandom % 4 != 0);
					exp_vid = ref_video(core_vid, odd, menu.scanlines);
					if (core_vid.vs) odd = 1'b0;
					else if (core_vid.hs && !hs_prev) odd = !odd;
					hs_prev = core_vid.hs;
					next_cycle();
					check_val("vid_out", 32'(exp_vid), 32'(vid_out));
				end
			end
		end
		end_test("video");

		samples[0] = 8'h00;
		samples[1] = 8'hFF;
		samples[2] = 8'($urandom);
		samples[3] = 8'($urandom);
		for (int s = 0; s < 4; s++) begin
			core_audio = samples[s];
			level16 = {samples[s], samples[s]};
			ones = 0;
			for (int i = 0; i < AUDIO_CYCLES; i++) begin
				next_cycle();
				ones = ones + 32'(audio_bit);
			end
			diff = longint'(ones) * 65536 - longint'(AUDIO_CYCLES) * longint'(level16);
			checks++;
			assert (diff <= 65536 && diff >= -65536) else begin
				$display("Fail audio_bit ones expected %h got %h", 32'(level16) >> 4, ones);
				errors++;
			end
		end
		end_test("audio");

		reset_request(1'b1);
		reset_request(1'b0);
		end_test("reset_request");

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* logic/arcade_glue_top.sv */
/*
 * Board glue around the arcade core: ROM load, core reset, controls,
 * video output stage and audio DAC
 */
`default_nettype none
`include "arcade_macros.svh"

module arcade_glue_top (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic dl_active,
	input  logic dl_wr,
	input  media_pkg::rom_wr_t dl_data,
	input  logic key_strobe,
	input  board_pkg::key_event_t key_event,
	input  board_pkg::joy_t joy0,
	input  board_pkg::joy_t joy1,
	input  logic board_reset_btn,
	input  board_pkg::menu_t menu,
	input  logic [`ROM_ADDR_W-1:0] rom_addr,
	input  media_pkg::vid_in_t core_vid,
	input  logic [7:0] core_audio,
	output logic [7:0] rom_data,
	output logic core_reset,
	output board_pkg::player_ctrl_t ctrl,
	output board_pkg::cabinet_t cabinet,
	output media_pkg::vid_out_t vid_out,
	output logic audio_bit
);

	rom_loader u_rom_loader (
		.clk_sys         (clk_sys),
		.rst_n           (rst_n),
		.dl_active       (dl_active),
		.dl_wr           (dl_wr),
		.dl_data         (dl_data),
		.rd_addr         (rom_addr), // Core reads straight from storage
		.rd_data         (rom_data),
		.menu_reset      (menu.reset_req),
		.board_reset_btn (board_reset_btn),
		.core_reset      (core_reset)
	);

	input_mapper u_input_mapper (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.key_strobe (key_strobe),
		.key_event  (key_event),
		.joy0       (joy0),
		.joy1       (joy1),
		.rotate     (menu.rotate),
		.ctrl       (ctrl),
		.cabinet    (cabinet)
	);

	video_blanker u_video_blanker (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.scanlines (menu.scanlines),
		.core_vid  (core_vid),
		.vid_out   (vid_out)
	);

	audio_dac u_audio_dac (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.sample    (core_audio),
		.audio_bit (audio_bit)
	);

endmodule

`default_nettype wire

/* logic/audio_dac.sv */
/*
 * First-order sigma-delta modulator for the 8-bit core audio
 */
`default_nettype none
`include "arcade_macros.svh"

module audio_dac (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic [7:0] sample,
	output logic audio_bit
);

	logic [`DAC_ACC_W-1:0] acc;
	logic [`DAC_ACC_W-1:0] level;
	logic [`DAC_ACC_W:0] sum; // Extra bit holds the carry

	assign level = {sample, sample}; // FF maps to full scale
	assign sum = {1'b0, acc} + {1'b0, level};

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			acc <= '0;
			audio_bit <= 1'b0;
		end else begin
			acc <= sum[`DAC_ACC_W-1:0];
			audio_bit <= sum[`DAC_ACC_W];
		end
	end

endmodule

`default_nettype wire

/* logic/video_blanker.sv */
/*
 * Video output stage: blanking, expansion to 6 bits per colour and
 * scanline dimming on odd lines
 */
`default_nettype none

module video_blanker (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic [1:0] scanlines,
	input  media_pkg::vid_in_t core_vid,
	output media_pkg::vid_out_t vid_out
);

	import media_pkg::*;

	logic hs_d;
	logic odd_line;
	vid_out_t vid_next;
	logic [2:0] b3;

	function automatic logic [5:0] dim(input logic [5:0] c, input logic [1:0] level);
		case (level)
			2'd1: dim = c - (c >> 2);
			2'd2: dim = c >> 1;
			2'd3: dim = c >> 2;
			default: dim = c;
		endcase
	endfunction

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			hs_d <= 1'b0;
			odd_line <= 1'b0;
		end else begin
			hs_d <= core_vid.hs;
			if (core_vid.vs) begin
				odd_line <= 1'b0; // Frame restarts on an even line
			end else if (core_vid.hs && !hs_d) begin
				odd_line <= !odd_line;
			end
		end
	end

	assign b3 = {core_vid.pix.b, core_vid.pix.b[0]};

	always_comb begin
		vid_next.hs = core_vid.hs;
		vid_next.vs = core_vid.vs;
		vid_next.r = {core_vid.pix.r, core_vid.pix.r};
		vid_next.g = {core_vid.pix.g, core_vid.pix.g};
		vid_next.b = {b3, b3};
		if (odd_line) begin
			vid_next.r = dim(vid_next.r, scanlines);
			vid_next.g = dim(vid_next.g, scanlines);
			vid_next.b = dim(vid_next.b, scanlines);
		end
		if (!core_vid.blankn) begin
			vid_next.r = '0;
			vid_next.g = '0;
			vid_next.b = '0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			vid_out <= '0;
		end else begin
			vid_out <= vid_next;
		end
	end

	a_blank_black: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!core_vid.blankn |=> vid_out.r == '0 && vid_out.g == '0 && vid_out.b == '0);

endmodule

`default_nettype wire

/* logic/input_mapper.sv */
/*
 * Player input mapping: keyboard button state, joystick merge and
 * optional quarter turn of the directions
 */
`default_nettype none
`include "arcade_macros.svh"

module input_mapper (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic key_strobe,
	input  board_pkg::key_event_t key_event,
	input  board_pkg::joy_t joy0,
	input  board_pkg::joy_t joy1,
	input  logic rotate,
	output board_pkg::player_ctrl_t ctrl,
	output board_pkg::cabinet_t cabinet
);

	import board_pkg::*;

	player_ctrl_t kb_ctrl; // Held keyboard buttons
	cabinet_t kb_cab;
	joy_t joy_any;
	player_ctrl_t ctrl_next;
	logic src_up;
	logic src_down;
	logic src_left;
	logic src_right;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			kb_ctrl <= '0;
			kb_cab <= '0;
		end else if (key_strobe) begin
			case (key_event.code)
				`KEY_UP:          kb_ctrl.up <= key_event.pressed;
				`KEY_DOWN:        kb_ctrl.down <= key_event.pressed;
				`KEY_LEFT:        kb_ctrl.left <= key_event.pressed;
				`KEY_RIGHT:       kb_ctrl.right <= key_event.pressed;
				`KEY_FIRE1:       kb_ctrl.fire1 <= key_event.pressed; // Space
				`KEY_FIRE2:       kb_ctrl.fire2 <= key_event.pressed; // Alt
				`KEY_FIRE3:       kb_ctrl.fire3 <= key_event.pressed; // Ctrl
				`KEY_FIRE4:       kb_ctrl.fire4 <= key_event.pressed; // Left shift
				`KEY_COIN:        kb_cab.coin <= key_event.pressed; // Esc
				`KEY_START1:      kb_cab.start1 <= key_event.pressed; // F1
				`KEY_START2:      kb_cab.start2 <= key_event.pressed; // F2
				`KEY_ADVANCE:     kb_cab.advance <= key_event.pressed;
				`KEY_AUTO_UP:     kb_cab.auto_up <= key_event.pressed;
				`KEY_SCORE_RESET: kb_cab.score_reset <= key_event.pressed;
				default: ; // Unmapped key
			endcase
		end
	end

	assign joy_any = joy0 | joy1;
	assign src_up = kb_ctrl.up | joy_any.up;
	assign src_down = kb_ctrl.down | joy_any.down;
	assign src_left = kb_ctrl.left | joy_any.left;
	assign src_right = kb_ctrl.right | joy_any.right;

	always_comb begin
		ctrl_next.fire1 = kb_ctrl.fire1 | joy_any.fire1;
		ctrl_next.fire2 = kb_ctrl.fire2 | joy_any.fire2;
		ctrl_next.fire3 = kb_ctrl.fire3 | joy_any.fire3;
		ctrl_next.fire4 = kb_ctrl.fire4 | joy_any.fire4;
		if (rotate) begin
			ctrl_next.up = src_up;
			ctrl_next.down = src_down;
			ctrl_next.left = src_left;
			ctrl_next.right = src_right;
		end else begin
			// Cabinet mounted on its side
			ctrl_next.up = src_right;
			ctrl_next.down = src_left;
			ctrl_next.left = src_up;
			ctrl_next.right = src_down;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			ctrl <= '0;
			cabinet <= '0;
		end else begin
			ctrl <= ctrl_next;
			cabinet <= kb_cab;
		end
	end

	// Opposing directions only come out together if some source asked for both
	a_no_up_down: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!(src_up && src_down) && !(src_left && src_right) |=> !(ctrl.up && ctrl.down));

endmodule

`default_nettype wire

/* logic/rom_loader.sv */
/*
 * ROM download handling: writes bytes into ROM storage, tracks load
 * completion and holds the game core in reset until it is ready
 */
`default_nettype none
`include "arcade_macros.svh"

module rom_loader (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic dl_active,
	input  logic dl_wr,
	input  media_pkg::rom_wr_t dl_data,
	input  logic [`ROM_ADDR_W-1:0] rd_addr,
	output logic [7:0] rd_data,
	input  logic menu_reset,
	input  logic board_reset_btn,
	output logic core_reset
);

	logic dl_active_d;
	logic wrote_any; // Current download has written a byte
	logic rom_loaded;

	rom_store u_rom_store (
		.clk_sys (clk_sys),
		.wr_en   (dl_wr),
		.wr      (dl_data),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			dl_active_d <= 1'b0;
			wrote_any <= 1'b0;
			rom_loaded <= 1'b0;
		end else begin
			dl_active_d <= dl_active;
			if (dl_wr) begin
				wrote_any <= 1'b1;
			end else if (dl_active && !dl_active_d) begin
				wrote_any <= 1'b0; // New download starts empty
			end
			if (dl_active_d && !dl_active && wrote_any) begin
				rom_loaded <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			core_reset <= 1'b1;
		end else begin
			core_reset <= !rom_loaded || dl_active || menu_reset || board_reset_btn;
		end
	end

	// Download bytes only arrive inside a download window
	a_wr_in_download: assert property (@(posedge clk_sys) disable iff (!rst_n)
		dl_wr |-> dl_active);

endmodule

`default_nettype wire

/* logic/rom_store.sv */
/*
 * Game ROM storage, byte wide, one write port and one registered read port
 */
`default_nettype none
`include "arcade_macros.svh"

module rom_store (
	input  logic clk_sys,
	input  logic wr_en,
	input  media_pkg::rom_wr_t wr,
	input  logic [`ROM_ADDR_W-1:0] rd_addr,
	output logic [7:0] rd_data
);

	localparam int DEPTH = 1 << `ROM_ADDR_W;

	logic [7:0] mem [0:DEPTH-1];

	always_ff @(posedge clk_sys) begin
		if (wr_en) begin
			mem[wr.addr] <= wr.data;
		end
	end

	always_ff @(posedge clk_sys) begin
		rd_data <= mem[rd_addr]; // One cycle read latency
	end

endmodule

`default_nettype wire

/* logic/media_pkg.sv */
/*
 * Media types: ROM download writes, core pixels, video in and out
 */
`default_nettype none
`include "arcade_macros.svh"

package media_pkg;

	typedef struct packed {
		logic [`ROM_ADDR_W-1:0] addr;
		logic [7:0] data;
	} rom_wr_t;

	typedef struct packed {
		logic [2:0] r;
		logic [2:0] g;
		logic [1:0] b;
	} pixel_t;

	typedef struct packed {
		pixel_t pix;
		logic hs;
		logic vs;
		logic blankn;
	} vid_in_t;

	typedef struct packed {
		logic [5:0] r;
		logic [5:0] g;
		logic [5:0] b;
		logic hs;
		logic vs;
	} vid_out_t;

endpackage

`default_nettype wire

/* logic/board_pkg.sv */
/*
 * Board-side types: key events, joysticks, player and cabinet controls, menu
 */
`default_nettype none
`include "arcade_macros.svh"

package board_pkg;

	typedef struct packed {
		logic pressed;
		logic [`KEY_CODE_W-1:0] code;
	} key_event_t;

	typedef struct packed {
		logic fire4;
		logic fire3;
		logic fire2;
		logic fire1;
		logic up;
		logic down;
		logic left;
		logic right; // Bit 0
	} joy_t;

	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire1;
		logic fire2;
		logic fire3;
		logic fire4;
	} player_ctrl_t;

	typedef struct packed {
		logic coin;
		logic start1;
		logic start2;
		logic advance;
		logic auto_up;
		logic score_reset;
	} cabinet_t;

	typedef struct packed {
		logic rotate;
		logic [1:0] scanlines; // 0 off, 1..3 dim depth
		logic reset_req;
	} menu_t;

endpackage

`default_nettype wire

/* logic/arcade_macros.svh */
/*
 * Arcade glue widths and keyboard scan codes
 */
`ifndef ARCADE_MACROS_SVH
`define ARCADE_MACROS_SVH

`define ROM_ADDR_W 15
`define DAC_ACC_W 16
`define KEY_CODE_W 8

// PS/2 set 2 make codes
`define KEY_UP 8'h75
`define KEY_DOWN 8'h72
`define KEY_LEFT 8'h6B
`define KEY_RIGHT 8'h74
`define KEY_COIN 8'h76
`define KEY_START1 8'h05
`define KEY_START2 8'h06
`define KEY_FIRE1 8'h29
`define KEY_FIRE2 8'h11
`define KEY_FIRE3 8'h14
`define KEY_FIRE4 8'h12
`define KEY_ADVANCE 8'h1C
`define KEY_AUTO_UP 8'h3C
`define KEY_SCORE_RESET 8'h33

`endif
